/* rtl/uart_rx_pkg.sv */
package uart_rx_pkg;

  // ---------------------------------------------------------------------
  // Timing and sizing constants
  // ---------------------------------------------------------------------

  // Oversampling strobes in one bit time
  localparam int OVERSAMPLE = 16;
  // Strobes from the falling start edge to the middle of the start bit
  localparam int HALF_BIT = 8;
  // Widest character that the receiver assembles
  localparam int DATA_W = 8;
  // Receive buffer depth and the pointer width that addresses it
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;
  // The fill count has to reach FIFO_DEPTH itself, hence one extra bit
  localparam int CNT_W = 5;
  // Clock cycles of held-low line before a configuration request is raised
  // Kept short so that simulation stays fast
  localparam int LINE_LOW_CYCLES = 2048;
  // Counter width able to hold LINE_LOW_CYCLES
  localparam int LOW_CNT_W = $clog2(LINE_LOW_CYCLES + 1);
  // One buffer entry holds the character plus two error flags
  localparam int ENTRY_W = DATA_W + 2;

  // ---------------------------------------------------------------------
  // Line configuration
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {DW_5BIT, DW_6BIT, DW_7BIT, DW_8BIT} data_width_e;

  // Encoding 2'b11 is unused and behaves like no parity
  typedef enum logic [1:0] {PAR_NONE, PAR_EVEN, PAR_ODD} parity_mode_e;

  typedef enum logic {SB_1BIT, SB_2BIT} stop_bits_e;

  typedef struct packed {
    data_width_e  width;
    parity_mode_e parity;
    stop_bits_e   stop;
  } rx_cfg_t;

  // A received character, right-aligned with zeros above the width
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              parity_err;
    logic              frame_err;
  } rx_frame_t;

  // The buffer moves raw words and the read side looks at the fields
  typedef union packed {
    logic [ENTRY_W-1:0] raw;
    rx_frame_t          fields;
  } rx_entry_u;

endpackage

/* rtl/uart_rx_frame_fsm.sv */
`timescale 1ns/1ps

module uart_rx_frame_fsm (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   ov_baud_rt_i,
  input  logic                   rx_i,
  input  uart_rx_pkg::rx_cfg_t   cfg_i,
  input  logic                   flush_i,
  output uart_rx_pkg::rx_frame_t frame_o,
  output logic                   frame_done_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_START, ST_SAMPLE, ST_PARITY, ST_STOP} rx_state_e;

  rx_state_e                      state_q;
  logic                           armed_q;
  logic [3:0]                     strb_cnt_q;
  logic [2:0]                     bit_cnt_q;
  logic [uart_rx_pkg::DATA_W-1:0] shift_q;
  logic                           par_acc_q;
  logic                           stop_ok_q;
  logic                           bit_tick;
  logic                           last_data;
  logic                           last_stop;
  logic [1:0]                     align_sh;

  // A bit is sampled on every OVERSAMPLE-th strobe after the start bit middle
  assign bit_tick = ov_baud_rt_i && (strb_cnt_q == 4'(uart_rx_pkg::OVERSAMPLE - 1));

  // Last data bit index is 4 for five bits up to 7 for eight bits
  assign last_data = (bit_cnt_q == ({1'b0, cfg_i.width} + 3'd4));

  // Stop bit index 0 ends a one-stop frame, index 1 a two-stop frame
  assign last_stop = (bit_cnt_q == {2'b00, cfg_i.stop});

  // ---------------------------------------------------------------------
  // Control state
  // ---------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      armed_q    <= 1'b0;
      strb_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (flush_i) begin
      // An acknowledged configuration request aborts the frame
      state_q <= ST_IDLE;
      armed_q <= 1'b0;
    end else begin
      // Bit-time counter shared by the data, parity and stop states
      if ((state_q inside {ST_SAMPLE, ST_PARITY, ST_STOP}) && ov_baud_rt_i) begin
        strb_cnt_q <= bit_tick ? '0 : strb_cnt_q + 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          strb_cnt_q <= '0;
          // The line must be seen high before a falling edge counts
          // so that a held-low line does not start frame after frame
          if (rx_i) begin
            armed_q <= 1'b1;
          end else if (armed_q) begin
            armed_q <= 1'b0;
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (ov_baud_rt_i) begin
            if (strb_cnt_q == 4'(uart_rx_pkg::HALF_BIT - 1)) begin
              strb_cnt_q <= '0;
              bit_cnt_q  <= '0;
              // A line that is back high in mid start bit was a glitch
              state_q    <= rx_i ? ST_IDLE : ST_SAMPLE;
            end else begin
              strb_cnt_q <= strb_cnt_q + 1'b1;
            end
          end
        end
        ST_SAMPLE: begin
          if (bit_tick) begin
            if (last_data) begin
              bit_cnt_q <= '0;
              if (cfg_i.parity inside {uart_rx_pkg::PAR_EVEN, uart_rx_pkg::PAR_ODD}) begin
                state_q <= ST_PARITY;
              end else begin
                state_q <= ST_STOP;
              end
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        ST_PARITY: begin
          if (bit_tick) begin
            state_q <= ST_STOP;
          end
        end
        ST_STOP: begin
          if (bit_tick) begin
            if (last_stop) begin
              state_q <= ST_IDLE;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Character datapath
  // ---------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    // Accumulators are primed while waiting for the start bit middle
    if (state_q == ST_START) begin
      par_acc_q <= 1'b0;
      stop_ok_q <= 1'b1;
    end
    if (bit_tick) begin
      // LSB arrives first, so bits enter at the top and move down
      if (state_q == ST_SAMPLE) begin
        shift_q   <= {rx_i, shift_q[uart_rx_pkg::DATA_W-1:1]};
        par_acc_q <= par_acc_q ^ rx_i;
      end
      if (state_q == ST_PARITY) begin
        par_acc_q <= par_acc_q ^ rx_i;
      end
      // Any low stop bit is remembered until the frame ends
      if (state_q == ST_STOP) begin
        stop_ok_q <= stop_ok_q & rx_i;
      end
    end
  end

  always_comb begin
    // Narrow characters sit high in the shift register and are moved down
    align_sh = 2'd3 - 2'(cfg_i.width);
    frame_o.data = shift_q >> align_sh;
    case (cfg_i.parity)
      uart_rx_pkg::PAR_EVEN: frame_o.parity_err = par_acc_q;
      uart_rx_pkg::PAR_ODD:  frame_o.parity_err = !par_acc_q;
      default:               frame_o.parity_err = 1'b0;
    endcase
    // The last stop bit is taken straight from the line in its sample cycle
    frame_o.frame_err = !(stop_ok_q && rx_i);
  end

  assign frame_done_o = (state_q == ST_STOP) && bit_tick && last_stop;

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------

  // Each frame hands exactly one completion pulse to the buffer
  a_done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    frame_done_o |=> !frame_done_o)
    else $error("frame_done_o stayed high for two cycles");

  // The monitor flush must leave the receiver waiting for a new start
  // A flush that kept the receiver armed would start a frame on a low line
  a_flush_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> (state_q == ST_IDLE) ##1 (state_q == ST_IDLE))
    else $error("receiver not idle after flush");

endmodule

/* rtl/uart_rx_line_monitor.sv */
`timescale 1ns/1ps

module uart_rx_line_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic rx_i,
  input  logic req_ackn_i,
  output logic config_req_o,
  output logic flush_o
);

  logic [uart_rx_pkg::LOW_CNT_W-1:0] low_cnt_q;
  logic                              req_q;
  logic                              low_done;

  // The host asks for configuration by holding the line low for a long time
  assign low_done = (low_cnt_q == uart_rx_pkg::LOW_CNT_W'(uart_rx_pkg::LINE_LOW_CYCLES));

  // An acknowledge only flushes when there is a request to acknowledge
  assign flush_o      = req_q && req_ackn_i;
  assign config_req_o = req_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      low_cnt_q <= '0;
      req_q     <= 1'b0;
    end else begin
      // Count consecutive low cycles and stop at the limit
      // Acknowledge restarts the count so a still-low line needs a full new period
      if (rx_i || flush_o) begin
        low_cnt_q <= '0;
      end else if (!low_done) begin
        low_cnt_q <= low_cnt_q + 1'b1;
      end
      // Acknowledge wins over a new request in the same cycle
      if (flush_o) begin
        req_q <= 1'b0;
      end else if (low_done) begin
        req_q <= 1'b1;
      end
    end
  end

  // Request drops right after acknowledge and does not bounce back
  // A line that is still low must not raise it again on the following edge
  a_ack_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (config_req_o && req_ackn_i) |=> !config_req_o ##1 !config_req_o)
    else $error("configuration request still set after acknowledge");

endmodule

/* rtl/uart_rx_buffer.sv */
`timescale 1ns/1ps

module uart_rx_buffer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  uart_rx_pkg::rx_frame_t        frame_i,
  input  logic                          frame_done_i,
  input  logic                          flush_i,
  input  logic                          rx_fifo_read_i,
  input  logic [uart_rx_pkg::CNT_W-1:0] threshold_i,
  output logic [uart_rx_pkg::DATA_W-1:0] data_rx_o,
  output logic                          parity_error_o,
  output logic                          frame_error_o,
  output logic                          overrun_error_o,
  output logic                          rxd_rdy_o,
  output logic                          rx_fifo_empty_o,
  output logic                          rx_fifo_full_o
);

  uart_rx_pkg::rx_entry_u              wr_entry_q;
  logic                                wr_pend_q;
  uart_rx_pkg::rx_entry_u              mem [uart_rx_pkg::FIFO_DEPTH];
  logic [uart_rx_pkg::FIFO_AW-1:0]     wr_ptr_q;
  logic [uart_rx_pkg::FIFO_AW-1:0]     rd_ptr_q;
  logic [uart_rx_pkg::CNT_W-1:0]       cnt_q;
  logic [uart_rx_pkg::CNT_W-1:0]       cnt_d;
  logic                                rdy_q;
  logic                                wr_en;
  logic                                rd_en;
  uart_rx_pkg::rx_entry_u              head;

  // ---------------------------------------------------------------------
  // Write stage
  // ---------------------------------------------------------------------

  // A completed frame is captured and written on the following edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_pend_q <= 1'b0;
    end else begin
      wr_pend_q <= frame_done_i && !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_done_i) begin
      wr_entry_q.fields <= frame_i;
    end
  end

  // Full and empty follow the registered fill count
  assign rx_fifo_empty_o = (cnt_q == '0);
  assign rx_fifo_full_o  = (cnt_q == uart_rx_pkg::CNT_W'(uart_rx_pkg::FIFO_DEPTH));

  // A frame that finds the buffer full is lost and flagged right away
  assign wr_en           = wr_pend_q && !rx_fifo_full_o && !flush_i;
  assign overrun_error_o = wr_pend_q && rx_fifo_full_o;

  // Reads of an empty buffer are ignored
  assign rd_en = rx_fifo_read_i && !rx_fifo_empty_o && !flush_i;

  // ---------------------------------------------------------------------
  // Storage and fill count
  // ---------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q].raw <= wr_entry_q.raw;
    end
  end

  always_comb begin
    if (flush_i) begin
      cnt_d = '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   cnt_d = cnt_q + 1'b1;
        2'b01:   cnt_d = cnt_q - 1'b1;
        // Simultaneous read and write keep the fill where it is
        default: cnt_d = cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      rdy_q    <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_d;
      // Ready level tracks the fill that this edge produces
      rdy_q <= (cnt_d >= threshold_i);
    end
  end

  assign rxd_rdy_o = rdy_q;

  // Head entry falls through, the flags only show during the read
  assign head           = mem[rd_ptr_q];
  assign data_rx_o      = head.fields.data;
  assign parity_error_o = head.fields.parity_err && rd_en;
  assign frame_error_o  = head.fields.frame_err && rd_en;

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------

  a_fill_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= uart_rx_pkg::CNT_W'(uart_rx_pkg::FIFO_DEPTH))
    else $error("fill count above buffer depth");

  // A full buffer without a read must not move its write pointer
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_fifo_full_o && !rd_en && !flush_i) |=>
      (rx_fifo_full_o && (wr_ptr_q == $past(wr_ptr_q))))
    else $error("buffer written while full");

endmodule

/* rtl/uart_rx_top.sv */
`timescale 1ns/1ps

module uart_rx_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           ov_baud_rt_i,
  input  logic                           rx_i,
  input  uart_rx_pkg::rx_cfg_t           cfg_i,
  input  logic [uart_rx_pkg::CNT_W-1:0]  threshold_i,
  input  logic                           rx_fifo_read_i,
  input  logic                           req_ackn_i,
  output logic [uart_rx_pkg::DATA_W-1:0] data_rx_o,
  output logic                           parity_error_o,
  output logic                           frame_error_o,
  output logic                           overrun_error_o,
  output logic                           rxd_rdy_o,
  output logic                           rx_fifo_empty_o,
  output logic                           rx_fifo_full_o,
  output logic                           config_req_o
);

  uart_rx_pkg::rx_frame_t frame;
  logic                   frame_done;
  logic                   flush;

  // Frame receiver turns the oversampled line into characters
  uart_rx_frame_fsm u_frame (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ov_baud_rt_i (ov_baud_rt_i),
    .rx_i         (rx_i),
    .cfg_i        (cfg_i),
    .flush_i      (flush),
    .frame_o      (frame),
    .frame_done_o (frame_done)
  );

  // Line monitor watches the same line for a configuration request
  uart_rx_line_monitor u_monitor (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rx_i         (rx_i),
    .req_ackn_i   (req_ackn_i),
    .config_req_o (config_req_o),
    .flush_o      (flush)
  );

  // Buffer queues characters and is emptied by the acknowledge flush
  uart_rx_buffer u_buffer (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .frame_i         (frame),
    .frame_done_i    (frame_done),
    .flush_i         (flush),
    .rx_fifo_read_i  (rx_fifo_read_i),
    .threshold_i     (threshold_i),
    .data_rx_o       (data_rx_o),
    .parity_error_o  (parity_error_o),
    .frame_error_o   (frame_error_o),
    .overrun_error_o (overrun_error_o),
    .rxd_rdy_o       (rxd_rdy_o),
    .rx_fifo_empty_o (rx_fifo_empty_o),
    .rx_fifo_full_o  (rx_fifo_full_o)
  );

endmodule

/* bench/uart_rx_checker.sv */
`timescale 1ns/1ps

module uart_rx_checker (
  input logic                           clk_i,
  input logic                           rx_fifo_read_i,
  input logic                           req_ackn_i,
  input logic                           config_req_i,
  input logic                           rx_fifo_empty_i,
  input logic                           overrun_error_i,
  input logic [uart_rx_pkg::DATA_W-1:0] data_rx_i,
  input logic                           parity_error_i,
  input logic                           frame_error_i
);

  // Entries still owed by the DUT, oldest at the front
  uart_rx_pkg::rx_frame_t exp_q[$];
  int reads_checked = 0;
  int mismatch_count = 0;
  int other_count = 0;
  int overrun_count = 0;

  // ---------------------------------------------------------------------
  // Services for the stimulus side
  // ---------------------------------------------------------------------

  task automatic push_expected(input uart_rx_pkg::rx_frame_t e);
    exp_q.push_back(e);
  endtask

  task automatic note_error(input string msg);
    $display("ERROR: %s at %0t", msg, $time);
    other_count++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      mismatch_count++;
    end
  endtask

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  function automatic int total_errors();
    return mismatch_count + other_count;
  endfunction

  task automatic report();
    $display("reads checked %0d, mismatches %0d, other errors %0d, overruns %0d",
             reads_checked, mismatch_count, other_count, overrun_count);
  endtask

  // ---------------------------------------------------------------------
  // Port watcher
  // ---------------------------------------------------------------------

  // Falling edge sits mid cycle, so every DUT output has settled here
  always @(negedge clk_i) begin
    uart_rx_pkg::rx_frame_t e;
    // An acknowledged request flushes everything the DUT still held
    if (config_req_i && req_ackn_i) begin
      exp_q.delete();
    end
    // A lost frame is always the newest one that was sent
    if (overrun_error_i) begin
      overrun_count++;
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_back());
      end else begin
        note_error("overrun reported while no character was expected");
      end
    end
    if (rx_fifo_read_i && !rx_fifo_empty_i) begin
      if (exp_q.size() == 0) begin
        note_error("a character was read that was never sent");
      end else begin
        e = exp_q.pop_front();
        reads_checked++;
        check_value("data_rx_o", 32'(data_rx_i), 32'(e.data));
        check_value("parity_error_o", 32'(parity_error_i), 32'(e.parity_err));
        check_value("frame_error_o", 32'(frame_error_i), 32'(e.frame_err));
      end
    end
  end

endmodule

/* bench/uart_rx_tb.sv */
`timescale 1ns/1ps

module uart_rx_tb;

  logic                           clk;
  logic                           rst_n;
  logic                           ov_baud_rt;
  logic                           rx;
  uart_rx_pkg::rx_cfg_t           cfg;
  logic [uart_rx_pkg::CNT_W-1:0]  threshold;
  logic                           rx_fifo_read;
  logic                           req_ackn;
  logic [uart_rx_pkg::DATA_W-1:0] data_rx;
  logic                           parity_error;
  logic                           frame_error;
  logic                           overrun_error;
  logic                           rxd_rdy;
  logic                           rx_fifo_empty;
  logic                           rx_fifo_full;
  logic                           config_req;
  logic [1:0]                     baud_div;
  integer                         seed;
  logic [31:0]                    rnd;

  uart_rx_top u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .ov_baud_rt_i    (ov_baud_rt),
    .rx_i            (rx),
    .cfg_i           (cfg),
    .threshold_i     (threshold),
    .rx_fifo_read_i  (rx_fifo_read),
    .req_ackn_i      (req_ackn),
    .data_rx_o       (data_rx),
    .parity_error_o  (parity_error),
    .frame_error_o   (frame_error),
    .overrun_error_o (overrun_error),
    .rxd_rdy_o       (rxd_rdy),
    .rx_fifo_empty_o (rx_fifo_empty),
    .rx_fifo_full_o  (rx_fifo_full),
    .config_req_o    (config_req)
  );

  uart_rx_checker u_check (
    .clk_i           (clk),
    .rx_fifo_read_i  (rx_fifo_read),
    .req_ackn_i      (req_ackn),
    .config_req_i    (config_req),
    .rx_fifo_empty_i (rx_fifo_empty),
    .overrun_error_i (overrun_error),
    .data_rx_i       (data_rx),
    .parity_error_i  (parity_error),
    .frame_error_i   (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Oversampling strobe on every fourth clock, so one bit is 64 clocks
  initial begin
    baud_div   = '0;
    ov_baud_rt = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      ov_baud_rt = (baud_div == 2'd3);
      baud_div   = baud_div + 2'd1;
    end
  end

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------

  // Expected buffer entry for one character sent under the given format
  function automatic uart_rx_pkg::rx_frame_t expected_entry(input logic [7:0] ch,
      input uart_rx_pkg::rx_cfg_t c, input logic bad_par, input logic [1:0] bad_stop);
    uart_rx_pkg::rx_frame_t e;
    int  n;
    int  i;
    logic p;
    logic x;
    n = 5 + int'(c.width);
    // Only the low n bits travel, the rest read back as zero
    for (i = 0; i < 8; i++) begin
      e.data[i] = (i < n) ? ch[i] : 1'b0;
    end
    // Parity bit as it appears on the line, inverted when sent wrong
    p = (^e.data) ^ (c.parity == uart_rx_pkg::PAR_ODD) ^ bad_par;
    x = (^e.data) ^ p;
    if (c.parity == uart_rx_pkg::PAR_EVEN) begin
      e.parity_err = x;
    end else if (c.parity == uart_rx_pkg::PAR_ODD) begin
      e.parity_err = !x;
    end else begin
      e.parity_err = 1'b0;
    end
    // Any low stop bit that the format actually samples is a framing error
    e.frame_err = bad_stop[0] || ((c.stop == uart_rx_pkg::SB_2BIT) && bad_stop[1]);
    return e;
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic drive_bit(input logic b);
    rx = b;
    step(uart_rx_pkg::OVERSAMPLE * 4);
  endtask

  task automatic set_cfg(input uart_rx_pkg::data_width_e w, input uart_rx_pkg::parity_mode_e p,
                         input uart_rx_pkg::stop_bits_e s);
    cfg.width  = w;
    cfg.parity = p;
    cfg.stop   = s;
  endtask

  // Expectation goes in first so that an overrun can retract it
  task automatic send_frame(input logic [7:0] ch, input logic bad_par,
                            input logic [1:0] bad_stop);
    int   n;
    int   i;
    logic p;
    n = 5 + int'(cfg.width);
    u_check.push_expected(expected_entry(ch, cfg, bad_par, bad_stop));
    drive_bit(1'b0);
    p = bad_par ^ (cfg.parity == uart_rx_pkg::PAR_ODD);
    for (i = 0; i < n; i++) begin
      drive_bit(ch[i]);
      p = p ^ ch[i];
    end
    if (cfg.parity == uart_rx_pkg::PAR_EVEN || cfg.parity == uart_rx_pkg::PAR_ODD) begin
      drive_bit(p);
    end
    drive_bit(!bad_stop[0]);
    if (cfg.stop == uart_rx_pkg::SB_2BIT) begin
      drive_bit(!bad_stop[1]);
    end
    // One idle bit lets the receiver re-arm on a high line
    drive_bit(1'b1);
  endtask

  task automatic send_random(input logic bad_par, input logic [1:0] bad_stop);
    rnd = $random(seed);
    send_frame(rnd[7:0], bad_par, bad_stop);
  endtask

  task automatic read_one();
    int waited;
    waited = 0;
    while (rx_fifo_empty && waited < 2000) begin
      step(1);
      waited++;
    end
    if (rx_fifo_empty) begin
      u_check.note_error("timed out waiting for a received character");
    end else begin
      rx_fifo_read = 1'b1;
      step(1);
      rx_fifo_read = 1'b0;
    end
  endtask

  task automatic wait_config_req();
    int waited;
    waited = 0;
    while (!config_req && waited < 4000) begin
      step(1);
      waited++;
    end
    if (!config_req) begin
      u_check.note_error("timed out waiting for the configuration request");
    end
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------

  initial begin
    int i;
    int w;
    int pm;
    int bad;
    seed         = 27;
    rst_n        = 1'b0;
    rx           = 1'b1;
    threshold    = 5'd1;
    rx_fifo_read = 1'b0;
    req_ackn     = 1'b0;
    set_cfg(uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT);
    step(16);
    rst_n = 1'b1;
    step(4);

    // Random 8N1 characters, read back in order
    for (i = 0; i < 6; i++) begin
      send_random(1'b0, 2'b00);
    end
    for (i = 0; i < 6; i++) begin
      read_one();
    end

    // Narrow widths with even and odd parity, good and bad parity bits
    for (w = 0; w < 3; w++) begin
      for (pm = 1; pm < 3; pm++) begin
        for (bad = 0; bad < 2; bad++) begin
          set_cfg(uart_rx_pkg::data_width_e'(2'(w)), uart_rx_pkg::parity_mode_e'(2'(pm)),
                  uart_rx_pkg::SB_1BIT);
          send_random(1'(bad), 2'b00);
          read_one();
        end
      end
    end

    // Low stop bits in one-stop and two-stop formats
    set_cfg(uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT);
    send_random(1'b0, 2'b01);
    read_one();
    set_cfg(uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_2BIT);
    send_random(1'b0, 2'b01);
    read_one();
    send_random(1'b0, 2'b10);
    read_one();
    send_random(1'b0, 2'b00);
    read_one();

    // Threshold ready level, then overrun on a full buffer
    set_cfg(uart_rx_pkg::DW_8BIT, uart_rx_pkg::PAR_NONE, uart_rx_pkg::SB_1BIT);
    threshold = 5'd5;
    step(2);
    u_check.check_value("rx_fifo_empty_o", 32'(rx_fifo_empty), 32'd1);
    for (i = 0; i < 4; i++) begin
      send_random(1'b0, 2'b00);
    end
    u_check.check_value("rxd_rdy_o", 32'(rxd_rdy), 32'd0);
    send_random(1'b0, 2'b00);
    u_check.check_value("rxd_rdy_o", 32'(rxd_rdy), 32'd1);
    for (i = 0; i < 13; i++) begin
      send_random(1'b0, 2'b00);
    end
    u_check.check_value("rx_fifo_full_o", 32'(rx_fifo_full), 32'd1);
    u_check.check_value("overrun count", 32'(u_check.overrun_count), 32'd2);
    for (i = 0; i < 16; i++) begin
      read_one();
    end
    u_check.check_value("rx_fifo_empty_o", 32'(rx_fifo_empty), 32'd1);
    u_check.check_value("pending entries", 32'(u_check.pending_count()), 32'd0);

    // Held-low line, acknowledge and flush, then a normal frame again
    threshold = 5'd1;
    send_random(1'b0, 2'b00);
    send_random(1'b0, 2'b00);
    rx = 1'b0;
    step(3000);
    wait_config_req();
    rx = 1'b1;
    step(2);
    req_ackn = 1'b1;
    step(1);
    req_ackn = 1'b0;
    step(2);
    u_check.check_value("config_req_o", 32'(config_req), 32'd0);
    u_check.check_value("rx_fifo_empty_o", 32'(rx_fifo_empty), 32'd1);
    u_check.check_value("pending entries", 32'(u_check.pending_count()), 32'd0);
    send_random(1'b0, 2'b00);
    read_one();
    step(10);
    u_check.check_value("pending entries", 32'(u_check.pending_count()), 32'd0);

    u_check.report();
    if (u_check.total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/uart_rx_pkg.sv
rtl/uart_rx_frame_fsm.sv
rtl/uart_rx_line_monitor.sv
rtl/uart_rx_buffer.sv
rtl/uart_rx_top.sv
bench/uart_rx_checker.sv
bench/uart_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module uart_rx_tb \
  -f filelist.f -o uart_rx_sim

out=$(./obj_dir/uart_rx_sim)
echo "$out"

# The run passes only when the pass message was printed
echo "$out" | grep -q "ALL TESTS PASSED"
